// File: list.f
rtl/lsu_pkg.sv
rtl/apb_pkg.sv
rtl/access_if.sv
rtl/lsu_ctrl.sv
rtl/store_align.sv
rtl/load_extend.sv
rtl/lsu_top.sv
tb/clk_gen.sv
tb/lsu_chk.sv
tb/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu_apb

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/apb_pkg.sv
      - rtl/access_if.sv
      - rtl/lsu_ctrl.sv
      - rtl/store_align.sv
      - rtl/load_extend.sv
      - rtl/lsu_top.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/lsu_chk.sv
      - tb/tb_lsu.sv

// File: tb/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu
  import lsu_pkg::*;
;

  localparam int addr_w      = 16;
  localparam int n_vec       = 27;
  localparam int cycle_limit = n_vec * 8 + 50;

  typedef struct packed {
    logic              write;
    acc_size_t         size;
    logic              sign;
    logic [addr_w-1:0] addr;
    word_t             wdata;
    word_t             exp_data;
    logic              exp_err;
  } vec_t;

  logic clk;
  logic nrst;

  logic              cmd_valid  = 1'b0;
  logic              cmd_write  = 1'b0;
  acc_size_t         cmd_size   = size_word;
  logic              cmd_signed = 1'b0;
  logic [addr_w-1:0] cmd_addr   = '0;
  word_t             cmd_wdata  = '0;
  logic              cmd_ready;
  logic              rsp_valid;
  word_t             rsp_data;
  logic              rsp_err;

  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  word_t             pwdata;
  strb_t             pstrb;
  word_t             prdata  = '0;
  logic              pready  = 1'b0;
  logic              pslverr = 1'b0;

  vec_t  tbl [n_vec];
  int    wait_tbl [n_vec];
  word_t mem [0:255];
  int    acc_idx   = 0;
  int    wait_left = 0;
  int    rsp_count = 0;
  int    errors    = 0;
  int    cycles    = 0;
  logic  bad_addr;
  logic [7:0] word_idx;

  clk_gen #(.period_ns(8), .rst_cycles(4)) clk0 (.clk(clk), .nrst(nrst));

  lsu_top #(.addr_w(addr_w)) dut0 (.*);

  // APB memory with a slave error from 0x0400 up
  assign bad_addr = (paddr >= 16'h0400);
  assign word_idx = paddr[9:2];

  always @(posedge clk) begin
    if (psel && !penable) begin
      // Bus address is the entry's address rounded down to a word
      assert (paddr === (tbl[acc_idx].addr & 16'hFFFC)) else begin
        $display("[FAIL] %0t paddr expected %h got %h", $time,
                 tbl[acc_idx].addr & 16'hFFFC, paddr);
        errors++;
      end
      wait_left <= wait_tbl[acc_idx];
      pready    <= (wait_tbl[acc_idx] == 0);
      pslverr   <= bad_addr;
      // A word comes back even on an error
      prdata    <= mem[word_idx];
    end else if (psel && penable) begin
      if (pready) begin
        if (pwrite && !bad_addr) begin
          for (int b = 0; b < 4; b++) begin
            if (pstrb[b]) mem[word_idx][8*b +: 8] <= pwdata[8*b +: 8];
          end
        end
        pready  <= 1'b0;
        pslverr <= 1'b0;
        acc_idx <= acc_idx + 1;
      end else begin
        wait_left <= wait_left - 1;
        pready    <= (wait_left == 1);
      end
    end
  end

  // Counted at the edge that ends each pulse
  always @(posedge clk) begin
    if (rsp_valid) rsp_count <= rsp_count + 1;
  end

  function automatic vec_t make_entry(input logic w, input acc_size_t s, input logic sg,
                                      input logic [addr_w-1:0] a, input word_t wd,
                                      input word_t ed, input logic ee);
    vec_t v;
    v = '{write: w, size: s, sign: sg, addr: a, wdata: wd, exp_data: ed, exp_err: ee};
    return v;
  endfunction

  task automatic fill_table();
    tbl[0]  = make_entry(1, size_word, 0, 16'h0010, 32'hDEADBEEF, 32'h00000000, 0);
    tbl[1]  = make_entry(0, size_word, 0, 16'h0010, 32'h0,        32'hDEADBEEF, 0);
    // Upper operand bits must not leak into other byte lanes
    tbl[2]  = make_entry(1, size_byte, 0, 16'h0020, 32'hFFFFFF11, 32'h00000000, 0);
    tbl[3]  = make_entry(1, size_byte, 0, 16'h0021, 32'hFFFFFF22, 32'h00000000, 0);
    tbl[4]  = make_entry(1, size_byte, 0, 16'h0022, 32'hFFFFFF33, 32'h00000000, 0);
    tbl[5]  = make_entry(1, size_byte, 0, 16'h0023, 32'hFFFFFF44, 32'h00000000, 0);
    tbl[6]  = make_entry(0, size_word, 0, 16'h0020, 32'h0,        32'h44332211, 0);
    tbl[7]  = make_entry(1, size_half, 0, 16'h0022, 32'h1234ABCD, 32'h00000000, 0);
    tbl[8]  = make_entry(0, size_word, 0, 16'h0020, 32'h0,        32'hABCD2211, 0);
    // Extension word holds bytes 80 7F FF 80 from lane 0 up
    tbl[9]  = make_entry(1, size_word, 0, 16'h0030, 32'h80FF7F80, 32'h00000000, 0);
    tbl[10] = make_entry(0, size_byte, 1, 16'h0030, 32'h0,        32'hFFFFFF80, 0);
    tbl[11] = make_entry(0, size_byte, 0, 16'h0030, 32'h0,        32'h00000080, 0);
    tbl[12] = make_entry(0, size_byte, 1, 16'h0031, 32'h0,        32'h0000007F, 0);
    tbl[13] = make_entry(0, size_byte, 0, 16'h0031, 32'h0,        32'h0000007F, 0);
    tbl[14] = make_entry(0, size_byte, 1, 16'h0032, 32'h0,        32'hFFFFFFFF, 0);
    tbl[15] = make_entry(0, size_byte, 0, 16'h0032, 32'h0,        32'h000000FF, 0);
    tbl[16] = make_entry(0, size_byte, 1, 16'h0033, 32'h0,        32'hFFFFFF80, 0);
    tbl[17] = make_entry(0, size_byte, 0, 16'h0033, 32'h0,        32'h00000080, 0);
    tbl[18] = make_entry(0, size_half, 1, 16'h0030, 32'h0,        32'h00007F80, 0);
    tbl[19] = make_entry(0, size_half, 0, 16'h0030, 32'h0,        32'h00007F80, 0);
    tbl[20] = make_entry(0, size_half, 1, 16'h0032, 32'h0,        32'hFFFF80FF, 0);
    tbl[21] = make_entry(0, size_half, 0, 16'h0032, 32'h0,        32'h000080FF, 0);
    // Misaligned addresses with low bits ignored per size
    tbl[22] = make_entry(0, size_half, 1, 16'h0033, 32'h0,        32'hFFFF80FF, 0);
    tbl[23] = make_entry(0, size_word, 0, 16'h0033, 32'h0,        32'h80FF7F80, 0);
    tbl[24] = make_entry(1, size_word, 0, 16'h0400, 32'h01234567, 32'h00000000, 1);
    tbl[25] = make_entry(0, size_word, 0, 16'h0404, 32'h0,        32'h00000000, 1);
    tbl[26] = make_entry(0, size_word, 0, 16'h0010, 32'h0,        32'hDEADBEEF, 0);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic run_entry(input int idx);
    vec_t v;
    v = tbl[idx];
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd_write  <= v.write;
    cmd_size   <= v.size;
    cmd_signed <= v.sign;
    cmd_addr   <= v.addr;
    cmd_wdata  <= v.wdata;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    // Taken on this edge
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    while (!rsp_valid) begin
      assert (!cmd_ready) else begin
        $display("cmd_ready went high before the response of entry %0d", idx);
        errors++;
      end
      @(negedge clk);
    end
    assert (rsp_count == idx) else begin
      $display("Response of entry %0d arrived out of order or duplicated", idx);
      errors++;
    end
    check_word("rsp_data", v.exp_data, rsp_data);
    check_word("rsp_err", word_t'(v.exp_err), word_t'(rsp_err));
  endtask

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the table did not finish", cycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    void'($urandom(26));
    fill_table();
    foreach (wait_tbl[i]) wait_tbl[i] = $urandom % 4;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5A000000 ^ (i * 32'h00010003);
    end
    wait (nrst === 1'b1);
    for (int i = 0; i < n_vec; i++) begin
      run_entry(i);
    end
    repeat (3) @(posedge clk);
    assert (rsp_count == n_vec) else begin
      $display("Got %0d responses for %0d commands", rsp_count, n_vec);
      errors++;
    end
    $display("Errors: %0d response checks, %0d protocol assertions",
             errors, dut0.chk0.fail_cnt);
    if (errors == 0 && dut0.chk0.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb/lsu_chk.sv
`timescale 1ns/100ps

module lsu_chk
  import lsu_pkg::*;
#(
  parameter int addr_w = 16
) (
  input logic              clk,
  input logic              nrst,
  input logic              psel,
  input logic              penable,
  input logic              pready,
  input logic              pwrite,
  input logic [addr_w-1:0] paddr,
  input word_t             pwdata,
  input strb_t             pstrb,
  input logic              cmd_ready,
  input logic              rsp_valid
);

  int fail_cnt = 0;

  a_enable_sel: assert property (@(posedge clk) disable iff (!nrst) penable |-> psel)
    else begin
      $error("penable high while psel is low");
      fail_cnt++;
    end

  // From setup until the completing edge nothing may move
  a_stable: assert property (@(posedge clk) disable iff (!nrst)
    (psel && !(penable && pready)) |=>
      (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata) && $stable(pstrb)))
    else begin
      $error("APB master outputs changed during a transfer");
      fail_cnt++;
    end

  a_busy: assert property (@(posedge clk) disable iff (!nrst) psel |-> !cmd_ready)
    else begin
      $error("cmd_ready high during an APB transfer");
      fail_cnt++;
    end

  a_pulse: assert property (@(posedge clk) disable iff (!nrst) rsp_valid |=> !rsp_valid)
    else begin
      $error("rsp_valid held for two cycles");
      fail_cnt++;
    end

endmodule

bind lsu_top lsu_chk #(.addr_w(addr_w)) chk0 (
  .clk       (clk),
  .nrst      (nrst),
  .psel      (psel),
  .penable   (penable),
  .pready    (pready),
  .pwrite    (pwrite),
  .paddr     (paddr),
  .pwdata    (pwdata),
  .pstrb     (pstrb),
  .cmd_ready (cmd_ready),
  .rsp_valid (rsp_valid)
);

// File: tb/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
  parameter int period_ns  = 8,
  parameter int rst_cycles = 4
) (
  output logic clk,
  output logic nrst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // Reset released on a rising edge after rst_cycles edges
  initial begin
    nrst = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    nrst <= 1'b1;
  end

endmodule

// File: rtl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter int addr_w = 16
) (
  input  logic              clk,
  input  logic              nrst,

  // Command and response
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic              cmd_write,
  input  acc_size_t         cmd_size,
  input  logic              cmd_signed,
  input  logic [addr_w-1:0] cmd_addr,
  input  word_t             cmd_wdata,
  output logic              rsp_valid,
  output word_t             rsp_data,
  output logic              rsp_err,

  // APB master
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output logic [addr_w-1:0] paddr,
  output word_t             pwdata,
  output strb_t             pstrb,
  input  word_t             prdata,
  input  logic              pready,
  input  logic              pslverr
);

  word_t load_data;

  access_if #(.addr_w(addr_w)) acc_bus ();

  lsu_ctrl #(
    .addr_w(addr_w)
  ) ctrl0 (
    .clk        (clk),
    .nrst       (nrst),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_write  (cmd_write),
    .cmd_size   (cmd_size),
    .cmd_signed (cmd_signed),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .acc        (acc_bus),
    .load_data  (load_data),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pready     (pready),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_err    (rsp_err)
  );

  // Store lanes and strobes
  store_align align0 (
    .acc    (acc_bus),
    .pwdata (pwdata),
    .pstrb  (pstrb)
  );

  // Load lane pick and extension
  load_extend ext0 (
    .acc       (acc_bus),
    .load_data (load_data)
  );

endmodule

// File: rtl/load_extend.sv
`timescale 1ns/100ps

module load_extend
  import lsu_pkg::*;
(
  access_if.load acc,
  output word_t  load_data
);

  word_t       byte_shift;
  logic [7:0]  byte_val;
  logic [15:0] half_val;

  // Lane selection
  assign byte_shift = acc.rdata >> (8 * acc.addr[1:0]);
  assign byte_val   = byte_shift[7:0];
  assign half_val   = acc.addr[1] ? acc.rdata[31:16] : acc.rdata[15:0];

  always_comb begin
    case (acc.size)
      size_byte: begin
        if (acc.is_signed) begin
          load_data = {{(data_w-8){byte_val[7]}}, byte_val};
        end else begin
          load_data = {{(data_w-8){1'b0}}, byte_val};
        end
      end
      size_half: begin
        if (acc.is_signed) begin
          load_data = {{(data_w-16){half_val[15]}}, half_val};
        end else begin
          load_data = {{(data_w-16){1'b0}}, half_val};
        end
      end
      default: begin
        load_data = acc.rdata;
      end
    endcase
  end

endmodule

// File: rtl/store_align.sv
`timescale 1ns/100ps

module store_align
  import lsu_pkg::*;
(
  access_if.store acc,
  output word_t   pwdata,
  output strb_t   pstrb
);

  logic [1:0] lane;

  assign lane = acc.addr[1:0];

  always_comb begin
    case (acc.size)
      size_byte: begin
        // One lane picked by both low address bits
        pwdata = word_t'(acc.wdata[7:0]) << (8 * lane);
        pstrb  = strb_t'(1) << lane;
      end
      size_half: begin
        // Bit 0 ignored, bit 1 picks the half
        if (lane[1]) begin
          pwdata = {acc.wdata[15:0], 16'h0000};
          pstrb  = 4'b1100;
        end else begin
          pwdata = {16'h0000, acc.wdata[15:0]};
          pstrb  = 4'b0011;
        end
      end
      default: begin
        pwdata = acc.wdata;
        pstrb  = {strb_w{1'b1}};
      end
    endcase
  end

endmodule

// File: rtl/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl
  import lsu_pkg::*;
  import apb_pkg::*;
#(
  parameter int addr_w = 16
) (
  input  logic              clk,
  input  logic              nrst,

  // Command side
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic              cmd_write,
  input  acc_size_t         cmd_size,
  input  logic              cmd_signed,
  input  logic [addr_w-1:0] cmd_addr,
  input  word_t             cmd_wdata,

  // Registered access towards the aligners
  access_if.ctrl            acc,
  input  word_t             load_data,

  // APB master
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output logic [addr_w-1:0] paddr,
  input  logic              pready,
  input  word_t             prdata,
  input  logic              pslverr,

  // Response side
  output logic              rsp_valid,
  output word_t             rsp_data,
  output logic              rsp_err
);

  apb_state_t state;
  logic       cmd_fire;
  logic       access_done;

  assign cmd_ready   = (state == st_idle);
  assign cmd_fire    = cmd_valid && cmd_ready;
  assign access_done = (state == st_access) && pready;

  // Phase sequencing, pready low simply holds st_access
  always_ff @(posedge clk) begin
    if (!nrst) begin
      state     <= st_idle;
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            state <= st_setup;
          end
        end
        st_setup: begin
          state <= st_access;
        end
        st_access: begin
          if (pready) begin
            state     <= st_idle;
            rsp_valid <= 1'b1;
            rsp_err   <= pslverr;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Command capture and read word capture
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      acc.write     <= cmd_write;
      acc.size      <= cmd_size;
      acc.is_signed <= cmd_signed;
      acc.addr      <= cmd_addr;
      acc.wdata     <= cmd_wdata;
    end
    if (access_done) begin
      acc.rdata <= prdata;
    end
  end

  // Bus outputs come straight from the held access
  assign psel    = (state != st_idle);
  assign penable = (state == st_access);
  assign pwrite  = acc.write;
  assign paddr   = {acc.addr[addr_w-1:2], 2'b00};

  // Extended load only for a clean read; acc still holds it during the pulse
  assign rsp_data = (rsp_valid && !acc.write && !rsp_err) ? load_data : '0;

endmodule

// File: rtl/access_if.sv
`timescale 1ns/100ps

interface access_if
  import lsu_pkg::*;
#(
  parameter int addr_w = 16
);

  // Registered access, held for the whole transfer
  logic              write;
  acc_size_t         size;
  logic              is_signed;
  logic [addr_w-1:0] addr;
  word_t             wdata;

  // Raw bus word captured at the end of the access
  word_t             rdata;

  modport ctrl (
    output write,
    output size,
    output is_signed,
    output addr,
    output wdata,
    output rdata
  );

  modport store (
    input size,
    input addr,
    input wdata
  );

  modport load (
    input size,
    input is_signed,
    input addr,
    input rdata
  );

endinterface

// File: rtl/apb_pkg.sv
package apb_pkg;

  // Master side phase of one APB transfer
  // Setup lasts one cycle, access holds until pready
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_setup  = 2'd1,
    st_access = 2'd2
  } apb_state_t;

endpackage

// File: rtl/lsu_pkg.sv
package lsu_pkg;

  // Data path geometry
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  typedef logic [data_w-1:0] word_t;
  typedef logic [strb_w-1:0] strb_t;

  // Access size as carried by the command
  // Encoding matches the reference memory stage (0 byte, 1 half, 2 word)
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } acc_size_t;

endpackage
